/* bench/write_back_tests.txt */
# Columns: command, first value, second value
# M inorder, S suppress, I unit rd, D unit, W cycles, E total completions
M 1 0
S 0 0
I 0 5
I 1 6
I 2 7
D 2 0
D 1 0
W 3 0
D 0 0
E 3 0
M 0 0
I 0 8
I 1 9
I 2 10
D 1 0
W 4 0
D 2 0
W 4 0
D 0 0
E 6 0
I 0 0
I 1 11
I 2 12
I 0 13
D 2 0
D 1 0
D 0 0
S 1 0
W 2 0
D 0 0
E 10 0
S 0 0

/* sources.f */
+incdir+src
src/wb_pkg.sv
src/id_order_stack.sv
src/inflight_table.sv
src/retire_select.sv
src/result_mux.sv
src/write_back.sv
bench/write_back_properties.sv
bench/write_back_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = write_back_tb
FILELIST   = sources.f
OBJDIR     = obj_dir
PASS_TEXT  = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o $(TOP)

sim: $(OBJDIR)/$(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* bench/write_back_tb.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module write_back_tb;

    // One in-flight instruction as the reference model sees it
    typedef struct {
        wb_pkg::id_t   id;
        int            unit;
        wb_pkg::raddr_t rd;
        bit            done;
        wb_pkg::word_t result;
    } entry_t;

    // An ID handed to a unit that has not reported it yet
    typedef struct {
        int          unit;
        wb_pkg::id_t id;
    } pend_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 inorder;
    logic                 suppress;
    logic                 issue;
    wb_pkg::unit_mask_t   issue_unit;
    wb_pkg::raddr_t       issue_rd;
    logic                 id_available;
    wb_pkg::id_t          issue_id;
    logic [`WB_UNITS-1:0] unit_done;
    wb_pkg::id_t          unit_id [`WB_UNITS-1:0];
    wb_pkg::word_t        unit_result [`WB_UNITS-1:0];
    wb_pkg::unit_mask_t   accepted;
    logic                 instruction_complete;
    logic                 rf_write;
    wb_pkg::raddr_t       rf_addr;
    wb_pkg::word_t        rf_data;
    wb_pkg::id_t          rf_id;
    logic                 queue_empty;

    int     errors = 0;
    int     comp_count = 0;
    time    wd_limit = 0;
    logic [15:0] lfsr_state = 16'd31690;

    // Reference model state
    entry_t inflight_q [$];
    pend_t  pending_q [$];
    bit     exp_valid = 1'b0;
    entry_t exp_entry;

    // Unit model state
    int start_cnt [`WB_UNITS];
    bit active [`WB_UNITS];
    bit drop_req [`WB_UNITS];

    // Parsed command stream
    string cmd_q [$];
    int    a_q [$];
    int    b_q [$];

    write_back i_write_back (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Galois form, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per result bit
    task automatic next_word(output wb_pkg::word_t w);
        w = '0;
        for (int i = 0; i < `WB_XLEN; i++) begin
            w = {w[`WB_XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Unit models
    //////////////////////////////////////////////////////////////

    // A unit keeps its report up until the cycle after its acknowledge
    always @(posedge clk) begin
        wb_pkg::word_t w;
        for (int u = 0; u < `WB_UNITS; u++) begin
            if (!rst_n) begin
                unit_done[u] <= 1'b0;
                active[u] = 1'b0;
            end else if (drop_req[u]) begin
                unit_done[u] <= 1'b0;
                drop_req[u] = 1'b0;
                active[u] = 1'b0;
            end else if (!active[u] && start_cnt[u] > 0) begin
                for (int k = 0; k < pending_q.size(); k++) begin
                    if (!active[u] && pending_q[k].unit == u) begin
                        next_word(w);
                        unit_done[u]   <= 1'b1;
                        unit_id[u]     <= pending_q[k].id;
                        unit_result[u] <= w;
                        pending_q.delete(k);
                        active[u] = 1'b1;
                        start_cnt[u]--;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Reference model and output checks
    //////////////////////////////////////////////////////////////

    // Outputs are sampled mid-cycle where every input and register is settled
    task automatic monitor_cycle();
        int     pick;
        int     uidx;
        bit     busy;
        logic [31:0] exp_acc;
        entry_t e;
        pick = -1;
        uidx = 0;
        busy = 1'b0;
        exp_acc = exp_valid ? (32'd1 << exp_entry.unit) : 32'd0;
        check_value("id_available", id_available, inflight_q.size() != `WB_DEPTH);
        check_value("queue_empty", queue_empty, inflight_q.size() == 0);
        check_value("instruction_complete", instruction_complete, exp_valid);
        check_value("accepted", accepted, exp_acc);
        check_value("rf_write", rf_write,
                    exp_valid && exp_entry.rd != '0 && !suppress);
        if (exp_valid && instruction_complete) begin
            check_value("rf_id", rf_id, exp_entry.id);
            check_value("rf_addr", rf_addr, exp_entry.rd);
            check_value("rf_data", rf_data, exp_entry.result);
            comp_count++;
        end
        // A new ID must not belong to an instruction still in flight
        if (issue) begin
            for (int k = 0; k < inflight_q.size(); k++) begin
                if (inflight_q[k].id == issue_id) begin
                    busy = 1'b1;
                end
            end
            check_value("issue_id_in_flight", busy, 1'b0);
        end
        for (int u = 0; u < `WB_UNITS; u++) begin
            if (accepted[u]) begin
                drop_req[u] = 1'b1;
            end
        end
        // Reports only count for IDs that are still in flight
        for (int u = 0; u < `WB_UNITS; u++) begin
            if (unit_done[u]) begin
                for (int k = 0; k < inflight_q.size(); k++) begin
                    if (inflight_q[k].id == unit_id[u]) begin
                        inflight_q[k].done   = 1'b1;
                        inflight_q[k].result = unit_result[u];
                    end
                end
            end
        end
        // In order only the head may go, otherwise the oldest done one
        if (inorder) begin
            if (inflight_q.size() > 0 && inflight_q[0].done) begin
                pick = 0;
            end
        end else begin
            for (int k = 0; k < inflight_q.size(); k++) begin
                if (pick < 0 && inflight_q[k].done) begin
                    pick = k;
                end
            end
        end
        exp_valid = (pick >= 0);
        if (exp_valid) begin
            exp_entry = inflight_q[pick];
            inflight_q.delete(pick);
        end
        // A new issue joins at the young end once the choice is made
        if (issue) begin
            for (int u = 0; u < `WB_UNITS; u++) begin
                if (issue_unit[u]) begin
                    uidx = u;
                end
            end
            e.id     = issue_id;
            e.unit   = uidx;
            e.rd     = issue_rd;
            e.done   = 1'b0;
            e.result = '0;
            inflight_q.push_back(e);
            pending_q.push_back('{unit: uidx, id: issue_id});
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            monitor_cycle();
        end
    end

    //////////////////////////////////////////////////////////////
    // Command stream
    //////////////////////////////////////////////////////////////

    task automatic load_tests();
        int    fd;
        int    n;
        int    a;
        int    b;
        string line;
        string cmd;
        fd = $fopen("bench/write_back_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test command file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            a = 0;
            b = 0;
            if (n > 0 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %d %d", cmd, a, b);
                if (n >= 2) begin
                    cmd_q.push_back(cmd);
                    a_q.push_back(a);
                    b_q.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input string cmd, input int a, input int b);
        int waited;
        waited = 0;
        case (cmd)
            "M": begin
                @(posedge clk);
                inorder <= a[0];
            end
            "S": begin
                @(posedge clk);
                suppress <= a[0];
            end
            "I": begin
                @(negedge clk);
                while (!id_available) begin
                    @(negedge clk);
                end
                @(posedge clk);
                issue      <= 1'b1;
                issue_unit <= wb_pkg::unit_mask_t'(1 << a);
                issue_rd   <= wb_pkg::raddr_t'(b);
                @(posedge clk);
                issue <= 1'b0;
            end
            "D": begin
                @(negedge clk);
                start_cnt[a]++;
            end
            "W": begin
                repeat (a) @(posedge clk);
            end
            "E": begin
                while (comp_count < a && waited < 64) begin
                    @(negedge clk);
                    waited++;
                end
                check_value("completions", comp_count, a);
            end
            default: begin
                $display("Unknown command %s in the test file", cmd);
                errors++;
            end
        endcase
    endtask

    initial begin
        rst_n       <= 1'b0;
        inorder     <= 1'b1;
        suppress    <= 1'b0;
        issue       <= 1'b0;
        issue_unit  <= '0;
        issue_rd    <= '0;
        unit_done   <= '0;
        for (int u = 0; u < `WB_UNITS; u++) begin
            unit_id[u]     <= '0;
            unit_result[u] <= '0;
            start_cnt[u]   = 0;
            drop_req[u]    = 1'b0;
        end
        load_tests();
        wd_limit = (cmd_q.size() + 1) * 64 * 100;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < cmd_q.size(); i++) begin
            run_command(cmd_q[i], a_q[i], b_q[i]);
        end
        repeat (4) @(posedge clk);
        errors += i_write_back.i_write_back_properties.fail_count;
        $display("Errors: %0d, completions: %0d", errors, comp_count);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog scaled by the number of commands
    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("Watchdog expired with commands still running");
        $display("Errors: %0d, completions: %0d", errors, comp_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* bench/write_back_properties.sv */
`timescale 1ns/1ps

module write_back_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 issue,
    input logic                 id_available,
    input logic                 queue_empty,
    input logic                 retire,
    input logic                 instruction_complete,
    input logic                 rf_write,
    input wb_pkg::unit_mask_t   accepted
);

    // Number of assertion failures so far
    int fail_count = 0;

    //////////////////////////////////////////////////////////////
    // Retirement outputs
    //////////////////////////////////////////////////////////////

    // Only one unit is acknowledged per retirement
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(accepted))
        else begin
            fail_count++;
            $error("accepted has more than one bit set");
        end

    // A register write only comes with a completion that acknowledges one unit
    assert property (@(posedge clk) disable iff (!rst_n)
        rf_write |-> (instruction_complete && $onehot(accepted)))
        else begin
            fail_count++;
            $error("rf_write without a completion acknowledging one unit");
        end

    //////////////////////////////////////////////////////////////
    // ID bookkeeping
    //////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) issue |-> id_available)
        else begin
            fail_count++;
            $error("issue while no ID is available");
        end

    // With nothing in flight no ID carries a done bit, so nothing retires
    assert property (@(posedge clk) disable iff (!rst_n) queue_empty |-> !retire)
        else begin
            fail_count++;
            $error("retirement while the queue is empty");
        end

endmodule

bind write_back write_back_properties i_write_back_properties (
    .clk                  (clk),
    .rst_n                (rst_n),
    .issue                (issue),
    .id_available         (id_available),
    .queue_empty          (queue_empty),
    .retire               (retire),
    .instruction_complete (instruction_complete),
    .rf_write             (rf_write),
    .accepted             (accepted)
);

/* src/write_back.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module write_back (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inorder,
    input  logic                 suppress,
    input  logic                 issue,
    input  wb_pkg::unit_mask_t   issue_unit,
    input  wb_pkg::raddr_t       issue_rd,
    output logic                 id_available,
    output wb_pkg::id_t          issue_id,
    input  logic [`WB_UNITS-1:0] unit_done,
    input  wb_pkg::id_t          unit_id [`WB_UNITS-1:0],
    input  wb_pkg::word_t        unit_result [`WB_UNITS-1:0],
    output wb_pkg::unit_mask_t   accepted,
    output logic                 instruction_complete,
    output logic                 rf_write,
    output wb_pkg::raddr_t       rf_addr,
    output wb_pkg::word_t        rf_data,
    output wb_pkg::id_t          rf_id,
    output logic                 queue_empty
);

    // Age-ordered ID list from the stack
    wb_pkg::id_t ordering [`WB_DEPTH-1:0];

    // Same-cycle retirement choice
    logic                 retire;
    wb_pkg::id_t          retire_id;
    logic [`WB_DEPTH-1:0] shift_mask;
    logic [`WB_DEPTH-1:0] id_done;

    // Retirement one cycle later and the packet it selects
    logic               retire_r;
    wb_pkg::id_t        ret_id_r;
    wb_pkg::unit_mask_t ret_unit;
    wb_pkg::raddr_t     ret_rd;
    logic               ret_rd_nzero;

    //////////////////////////////////////////////////////////////
    // Bookkeeping
    //////////////////////////////////////////////////////////////

    id_order_stack i_id_order_stack (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .retire       (retire),
        .shift_mask   (shift_mask),
        .retire_id    (retire_id),
        .ordering     (ordering),
        .next_id      (issue_id),
        .id_available (id_available),
        .queue_empty  (queue_empty)
    );

    // Issue always takes the ID the stack is offering
    inflight_table i_inflight_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .issue_id     (issue_id),
        .issue_unit   (issue_unit),
        .issue_rd     (issue_rd),
        .unit_done    (unit_done),
        .unit_id      (unit_id),
        .retire       (retire),
        .retire_id    (retire_id),
        .ret_id_r     (ret_id_r),
        .id_done      (id_done),
        .ret_unit     (ret_unit),
        .ret_rd       (ret_rd),
        .ret_rd_nzero (ret_rd_nzero)
    );

    //////////////////////////////////////////////////////////////
    // Retirement and result path
    //////////////////////////////////////////////////////////////

    retire_select i_retire_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .inorder    (inorder),
        .ordering   (ordering),
        .id_done    (id_done),
        .retire     (retire),
        .retire_id  (retire_id),
        .shift_mask (shift_mask),
        .retire_r   (retire_r),
        .ret_id_r   (ret_id_r)
    );

    result_mux i_result_mux (
        .retire_r             (retire_r),
        .ret_id_r             (ret_id_r),
        .ret_unit             (ret_unit),
        .ret_rd               (ret_rd),
        .ret_rd_nzero         (ret_rd_nzero),
        .suppress             (suppress),
        .unit_result          (unit_result),
        .accepted             (accepted),
        .instruction_complete (instruction_complete),
        .rf_write             (rf_write),
        .rf_addr              (rf_addr),
        .rf_data              (rf_data),
        .rf_id                (rf_id)
    );

endmodule

/* src/result_mux.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module result_mux (
    input  logic               retire_r,
    input  wb_pkg::id_t        ret_id_r,
    input  wb_pkg::unit_mask_t ret_unit,
    input  wb_pkg::raddr_t     ret_rd,
    input  logic               ret_rd_nzero,
    input  logic               suppress,
    input  wb_pkg::word_t      unit_result [`WB_UNITS-1:0],
    output wb_pkg::unit_mask_t accepted,
    output logic               instruction_complete,
    output logic               rf_write,
    output wb_pkg::raddr_t     rf_addr,
    output wb_pkg::word_t      rf_data,
    output wb_pkg::id_t        rf_id
);

    // The owner mask is one-hot, so gating it gives a single acknowledge
    assign accepted = ret_unit & {`WB_UNITS{retire_r}};

    assign instruction_complete = retire_r;

    //////////////////////////////////////////////////////////////
    // Register file write port
    //////////////////////////////////////////////////////////////

    // No write for register zero or while write-back is held off
    assign rf_write = retire_r & ret_rd_nzero & ~suppress;
    assign rf_addr  = ret_rd;
    assign rf_id    = ret_id_r;

    // AND-OR pick of the owning unit's held result
    always_comb begin
        rf_data = '0;
        for (int u = 0; u < `WB_UNITS; u++) begin
            rf_data |= unit_result[u] & {`WB_XLEN{ret_unit[u]}};
        end
    end

endmodule

/* src/retire_select.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module retire_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inorder,
    input  wb_pkg::id_t          ordering [`WB_DEPTH-1:0],
    input  logic [`WB_DEPTH-1:0] id_done,
    output logic                 retire,
    output wb_pkg::id_t          retire_id,
    output logic [`WB_DEPTH-1:0] shift_mask,
    output logic                 retire_r,
    output wb_pkg::id_t          ret_id_r
);

    // Done bits rearranged so that bit i belongs to list slot i
    logic [`WB_DEPTH-1:0] done_by_age;

    //////////////////////////////////////////////////////////////
    // Oldest done search
    //////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `WB_DEPTH; i++) begin
            done_by_age[i] = id_done[ordering[i]];
        end
    end

    // Walk from the newest slot to the oldest, so the last hit wins and
    // names the oldest done instruction
    // Slot zero is the default and is always part of the shift
    always_comb begin
        retire_id     = ordering[0];
        shift_mask    = '0;
        shift_mask[0] = 1'b1;
        for (int i = 1; i < `WB_DEPTH; i++) begin
            if (done_by_age[i]) begin
                retire_id = ordering[i];
                for (int j = 0; j <= i; j++) begin
                    shift_mask[j] = 1'b1;
                end
            end
        end
    end

    // In order, only the top slot may leave and then the search above
    // already points at it
    // Free IDs never carry a done bit, so an empty list retires nothing
    assign retire = inorder ? done_by_age[`WB_DEPTH-1] : |done_by_age;

    //////////////////////////////////////////////////////////////
    // Retirement register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_r <= 1'b0;
        end else begin
            retire_r <= retire;
        end
    end

    // ID only matters while retire_r is high
    always_ff @(posedge clk) begin
        ret_id_r <= retire_id;
    end

endmodule

/* src/inflight_table.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module inflight_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  wb_pkg::id_t           issue_id,
    input  wb_pkg::unit_mask_t    issue_unit,
    input  wb_pkg::raddr_t        issue_rd,
    input  logic [`WB_UNITS-1:0]  unit_done,
    input  wb_pkg::id_t           unit_id [`WB_UNITS-1:0],
    input  logic                  retire,
    input  wb_pkg::id_t           retire_id,
    input  wb_pkg::id_t           ret_id_r,
    output logic [`WB_DEPTH-1:0]  id_done,
    output wb_pkg::unit_mask_t    ret_unit,
    output wb_pkg::raddr_t        ret_rd,
    output logic                  ret_rd_nzero
);

    // Packet fields written at issue and read back at retirement
    wb_pkg::unit_mask_t owner_tbl [`WB_DEPTH-1:0];
    wb_pkg::raddr_t     rd_tbl    [`WB_DEPTH-1:0];
    logic               nzero_tbl [`WB_DEPTH-1:0];

    // Set while an ID belongs to an issued, not yet retired instruction
    logic [`WB_DEPTH-1:0] id_live;

    // Reports seen this cycle and reports held from earlier cycles
    logic [`WB_DEPTH-1:0] done_fresh;
    logic [`WB_DEPTH-1:0] done_sticky;

    //////////////////////////////////////////////////////////////
    // Packet table
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (issue) begin
            owner_tbl[issue_id] <= issue_unit;
            rd_tbl[issue_id]    <= issue_rd;
            // Register zero is never written, so remember that now
            nzero_tbl[issue_id] <= (issue_rd != '0);
        end
    end

    // A unit keeps its report up during the cycle it is acknowledged, which
    // is after its ID has already retired. The live bit hides that echo
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_live <= '0;
        end else begin
            for (int i = 0; i < `WB_DEPTH; i++) begin
                if (retire && retire_id == wb_pkg::id_t'(i)) begin
                    id_live[i] <= 1'b0;
                end else if (issue && issue_id == wb_pkg::id_t'(i)) begin
                    id_live[i] <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Done tracking
    //////////////////////////////////////////////////////////////

    // OR every unit report that names the same ID
    always_comb begin
        done_fresh = '0;
        for (int i = 0; i < `WB_DEPTH; i++) begin
            for (int u = 0; u < `WB_UNITS; u++) begin
                if (unit_done[u] && unit_id[u] == wb_pkg::id_t'(i)) begin
                    done_fresh[i] = id_live[i];
                end
            end
        end
    end

    // A report that is not serviced stays recorded until its ID retires
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WB_DEPTH; i++) begin
            if (!rst_n || (retire && retire_id == wb_pkg::id_t'(i))) begin
                done_sticky[i] <= 1'b0;
            end else if (done_fresh[i]) begin
                done_sticky[i] <= 1'b1;
            end
        end
    end

    assign id_done = done_sticky | done_fresh;

    // Fields of the instruction retired on the previous edge
    assign ret_unit     = owner_tbl[ret_id_r];
    assign ret_rd       = rd_tbl[ret_id_r];
    assign ret_rd_nzero = nzero_tbl[ret_id_r];

endmodule

/* src/id_order_stack.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module id_order_stack (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue,
    input  logic             retire,
    input  logic [`WB_DEPTH-1:0] shift_mask,
    input  wb_pkg::id_t      retire_id,
    output wb_pkg::id_t      ordering [`WB_DEPTH-1:0],
    output wb_pkg::id_t      next_id,
    output logic             id_available,
    output logic             queue_empty
);

    // Index of the oldest slot in the list
    localparam wb_pkg::id_t top_slot = wb_pkg::id_t'(`WB_DEPTH - 1);

    // Number of instructions in flight, zero up to the full depth
    logic [`WB_ID_W:0] inflight_count;

    // Highest slot that still holds a free ID
    wb_pkg::id_t free_slot;

    //////////////////////////////////////////////////////////////
    // ID list
    //////////////////////////////////////////////////////////////

    // In-flight IDs fill the list from the top slot downwards, so the
    // oldest instruction always sits at the highest index
    // Free IDs occupy the slots below them
    // Issue needs no movement: the highest free slot simply becomes the
    // newest in-flight entry once the counter steps up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_DEPTH; i++) begin
                ordering[i] <= wb_pkg::id_t'(i);
            end
        end else if (retire) begin
            // Every slot below the retiring one moves up by one place
            for (int i = 1; i < `WB_DEPTH; i++) begin
                if (shift_mask[i]) begin
                    ordering[i] <= ordering[i-1];
                end
            end
            // The retired ID drops back in as the lowest free entry
            if (shift_mask[0]) begin
                ordering[0] <= retire_id;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // In-flight counter
    //////////////////////////////////////////////////////////////

    // Issue and retirement in the same cycle leave the count alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight_count <= '0;
        end else begin
            case ({issue, retire})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // The wrap at a full list is harmless since id_available is low then
    assign free_slot = top_slot - inflight_count[`WB_ID_W-1:0];
    assign next_id   = ordering[free_slot];

    // Availability ends once every ID is handed out
    assign id_available = (inflight_count != (`WB_ID_W+1)'(`WB_DEPTH));
    assign queue_empty  = (inflight_count == '0);

endmodule

/* src/wb_pkg.sv */
`include "wb_consts.svh"

package wb_pkg;

    //////////////////////////////////////////////////////////////
    // Shared write-back types
    //////////////////////////////////////////////////////////////

    // Tag carried by an instruction from issue to retirement
    typedef logic [`WB_ID_W-1:0] id_t;

    // One-hot set of function units, one bit per unit
    typedef logic [`WB_UNITS-1:0] unit_mask_t;

    // Destination register number
    typedef logic [`WB_RADDR_W-1:0] raddr_t;

    // Result value produced by a unit
    typedef logic [`WB_XLEN-1:0] word_t;

endpackage

/* src/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

//////////////////////////////////////////////////////////////
// Write-back sizing
//////////////////////////////////////////////////////////////

// Function units that report completions to write-back
`define WB_UNITS 3

// Instructions that may be in flight at once
`define WB_DEPTH 4

// Instruction ID width, enough to name every in-flight slot
`define WB_ID_W 2

// Result word width
`define WB_XLEN 32

// Register file address width
`define WB_RADDR_W 5

`endif
